//--- include/i2c_cfg.svh
// I2C master configuration
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// ----------------------------------------
// bus addressing
// ----------------------------------------
`define I2C_SLAVE_ADDR 7'b1010000    // eeprom device address
`define I2C_BYTE_W     8             // data byte width
`define I2C_WADDR_W    16            // full word address width

// ----------------------------------------
// timing in dri_clk cycles
// ----------------------------------------
// dri_clk runs at four times the scl rate, so one bit is four steps
`define I2C_BIT_STEPS  4             // per bit, ack slot included
`define I2C_STOP_STEPS 17            // whole stop command

`endif

//--- rtl/i2c_pkg.sv
// I2C master types
`default_nettype none

package i2c_pkg;

    // ----------------------------------------
    // byte engine commands
    // ----------------------------------------
    typedef enum logic [2:0] {
        OP_START_WR,    // start, then byte with ack
        OP_RESTART,     // repeated start, then byte with ack
        OP_WRITE,       // byte with ack
        OP_READ,        // byte in, master nack
        OP_STOP         // stop condition
    } i2c_op_e;

    // ----------------------------------------
    // transaction sequencer states
    // ----------------------------------------
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SLADDR,      // device address, write bit
        ST_ADDR_HI,     // upper word address byte
        ST_ADDR_LO,     // lower word address byte
        ST_DATA_WR,
        ST_ADDR_RD,     // device address, read bit
        ST_DATA_RD,
        ST_STOP
    } i2c_state_e;

endpackage

`default_nettype wire

//--- rtl/i2c_byte_engine.sv
// I2C byte engine
`timescale 1ns/1ns
`include "i2c_cfg.svh"
`default_nettype none

module i2c_byte_engine (
    input  logic                   dri_clk,
    input  logic                   rst_n,
    input  logic                   op_go,          // one-cycle command strobe
    input  i2c_pkg::i2c_op_e       op,
    input  logic [`I2C_BYTE_W-1:0] tx_byte,
    input  logic                   sda_in,         // pad value
    output logic                   op_done,
    output logic                   ack_n,          // high: slave did not ack
    output logic [`I2C_BYTE_W-1:0] rx_byte,
    output logic                   scl,
    output logic                   sda_drive_low
);

    localparam logic [4:0] BIT_LAST  = 5'(`I2C_BIT_STEPS - 1);
    localparam logic [4:0] STOP_LAST = 5'(`I2C_STOP_STEPS - 1);
    localparam logic [3:0] ACK_SLOT  = 4'(`I2C_BYTE_W);

    i2c_pkg::i2c_op_e       op_r;
    logic                   busy;
    logic                   in_start;       // start prefix still running
    logic [4:0]             step;           // quarter-period step
    logic [3:0]             bit_idx;        // 0..7 data, 8 ack slot
    logic [`I2C_BYTE_W-1:0] shreg;
    logic                   is_stop;
    logic                   is_read;
    logic                   ack_slot;
    logic                   first_low;

    assign is_stop  = (op_r == i2c_pkg::OP_STOP);
    assign is_read  = (op_r == i2c_pkg::OP_READ);
    assign ack_slot = (bit_idx == ACK_SLOT);
    assign rx_byte  = shreg;

    // last cycle of the command
    assign op_done = busy && (is_stop ? (step == STOP_LAST)
                                      : (!in_start && ack_slot && (step == BIT_LAST)));

    // step 0 of every command is done in the op_go cycle itself
    always_comb begin
        case (op)
            i2c_pkg::OP_STOP:  first_low = 1'b1;                      // hold sda low
            i2c_pkg::OP_WRITE: first_low = ~tx_byte[`I2C_BYTE_W-1];   // data msb
            default:           first_low = 1'b0;                      // released
        endcase
    end

    // ----------------------------------------
    // phase sequencing
    // ----------------------------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            op_r          <= i2c_pkg::OP_STOP;
            in_start      <= 1'b0;
            step          <= '0;
            bit_idx       <= '0;
            ack_n         <= 1'b0;
            scl           <= 1'b1;            // bus idle
            sda_drive_low <= 1'b0;
        end
        else if (!busy) begin
            if (op_go) begin
                busy          <= 1'b1;
                op_r          <= op;
                in_start      <= (op == i2c_pkg::OP_START_WR) ||
                                 (op == i2c_pkg::OP_RESTART);
                step          <= 5'd1;
                bit_idx       <= '0;
                sda_drive_low <= first_low;
            end
        end
        else if (is_stop) begin
            case (step)
                5'd1:    scl           <= 1'b1;
                5'd3:    sda_drive_low <= 1'b0;   // sda rises while scl high
                default: ;
            endcase
            step <= step + 5'd1;
            if (op_done) begin
                busy <= 1'b0;
            end
        end
        else begin
            // prefix uses steps 1..3, each bit uses steps 0..3
            step <= (step == BIT_LAST) ? 5'd0 : step + 5'd1;
            case (step)
                5'd0: begin
                    sda_drive_low <= !(is_read || ack_slot) && !shreg[`I2C_BYTE_W-1];
                end
                5'd1: begin
                    scl <= 1'b1;
                end
                5'd2: begin
                    if (in_start) begin
                        sda_drive_low <= 1'b1;    // start: sda falls, scl high
                    end
                    else if (ack_slot && !is_read) begin
                        ack_n <= sda_in;          // sample slave ack
                    end
                end
                5'd3: begin
                    scl <= 1'b0;
                    if (in_start) begin
                        in_start <= 1'b0;
                    end
                    else begin
                        bit_idx <= bit_idx + 4'd1;
                    end
                    if (op_done) begin
                        busy <= 1'b0;
                    end
                end
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // shared tx/rx shift register
    // ----------------------------------------
    // shifts as scl rises, so a write captures its own echo and a read its data
    always_ff @(posedge dri_clk) begin
        if (!busy && op_go) begin
            shreg <= tx_byte;
        end
        else if (busy && !is_stop && !in_start && !ack_slot && (step == 5'd1)) begin
            shreg <= {shreg[`I2C_BYTE_W-2:0], sda_in};
        end
    end

endmodule

`default_nettype wire

//--- rtl/i2c_seq.sv
// I2C transaction sequencer
`timescale 1ns/1ns
`include "i2c_cfg.svh"
`default_nettype none

module i2c_seq (
    input  logic                    dri_clk,
    input  logic                    rst_n,
    input  logic                    i2c_exec,
    input  logic                    bit_ctrl,      // high for a 16-bit word address
    input  logic                    i2c_rh_wl,     // high for a read
    input  logic [`I2C_WADDR_W-1:0] i2c_addr,
    input  logic [`I2C_BYTE_W-1:0]  i2c_data_w,
    input  logic                    op_done,
    input  logic                    ack_n,
    input  logic [`I2C_BYTE_W-1:0]  rx_byte,
    output logic                    op_go,
    output i2c_pkg::i2c_op_e        op,
    output logic [`I2C_BYTE_W-1:0]  tx_byte,
    output logic [`I2C_BYTE_W-1:0]  i2c_data_r,
    output logic                    i2c_done,
    output logic                    i2c_ack
);

    i2c_pkg::i2c_state_e     state;
    i2c_pkg::i2c_state_e     nxt_state;
    i2c_pkg::i2c_op_e        nxt_op;
    logic [`I2C_BYTE_W-1:0]  nxt_byte;
    logic                    advance;
    logic                    cmd_active;    // engine command in flight
    logic                    bit_ctrl_r;
    logic                    rd_r;
    logic [`I2C_WADDR_W-1:0] addr_r;
    logic [`I2C_BYTE_W-1:0]  data_w_r;

    // idle takes a request and every other state moves on the engine's done
    assign advance = (state == i2c_pkg::ST_IDLE) ? i2c_exec : (cmd_active && op_done);

    // ----------------------------------------
    // next state and the command it starts
    // ----------------------------------------
    always_comb begin
        nxt_state = state;
        nxt_op    = i2c_pkg::OP_STOP;
        nxt_byte  = '0;
        case (state)
            i2c_pkg::ST_IDLE: begin
                nxt_state = i2c_pkg::ST_SLADDR;
                nxt_op    = i2c_pkg::OP_START_WR;
                nxt_byte  = {`I2C_SLAVE_ADDR, 1'b0};
            end
            i2c_pkg::ST_SLADDR: begin
                nxt_op = i2c_pkg::OP_WRITE;
                if (bit_ctrl_r) begin
                    nxt_state = i2c_pkg::ST_ADDR_HI;
                    nxt_byte  = addr_r[`I2C_WADDR_W-1 -: `I2C_BYTE_W];
                end
                else begin
                    nxt_state = i2c_pkg::ST_ADDR_LO;
                    nxt_byte  = addr_r[`I2C_BYTE_W-1:0];
                end
            end
            i2c_pkg::ST_ADDR_HI: begin
                nxt_state = i2c_pkg::ST_ADDR_LO;
                nxt_op    = i2c_pkg::OP_WRITE;
                nxt_byte  = addr_r[`I2C_BYTE_W-1:0];
            end
            i2c_pkg::ST_ADDR_LO: begin
                if (rd_r) begin
                    nxt_state = i2c_pkg::ST_ADDR_RD;
                    nxt_op    = i2c_pkg::OP_RESTART;
                    nxt_byte  = {`I2C_SLAVE_ADDR, 1'b1};
                end
                else begin
                    nxt_state = i2c_pkg::ST_DATA_WR;
                    nxt_op    = i2c_pkg::OP_WRITE;
                    nxt_byte  = data_w_r;
                end
            end
            i2c_pkg::ST_ADDR_RD: begin
                nxt_state = i2c_pkg::ST_DATA_RD;
                nxt_op    = i2c_pkg::OP_READ;
            end
            i2c_pkg::ST_DATA_WR,
            i2c_pkg::ST_DATA_RD: nxt_state = i2c_pkg::ST_STOP;
            default:             nxt_state = i2c_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= i2c_pkg::ST_IDLE;
            op_go      <= 1'b0;
            op         <= i2c_pkg::OP_STOP;
            cmd_active <= 1'b0;
            bit_ctrl_r <= 1'b0;
            rd_r       <= 1'b0;
            i2c_data_r <= '0;
            i2c_done   <= 1'b0;
            i2c_ack    <= 1'b0;
        end
        else begin
            op_go    <= 1'b0;
            i2c_done <= 1'b0;
            if (op_go) begin
                cmd_active <= 1'b1;
            end
            else if (op_done) begin
                cmd_active <= 1'b0;
            end
            if (advance) begin
                state <= nxt_state;
                op_go <= (nxt_state != i2c_pkg::ST_IDLE);
                op    <= nxt_op;
                case (state)
                    i2c_pkg::ST_IDLE: begin
                        bit_ctrl_r <= bit_ctrl;
                        rd_r       <= i2c_rh_wl;
                        i2c_ack    <= 1'b0;
                    end
                    i2c_pkg::ST_DATA_RD: i2c_data_r <= rx_byte;
                    i2c_pkg::ST_STOP:    i2c_done   <= 1'b1;
                    default:             i2c_ack    <= i2c_ack | ack_n;
                endcase
            end
        end
    end

    // request fields and the outgoing byte
    always_ff @(posedge dri_clk) begin
        if (advance) begin
            tx_byte <= nxt_byte;
            if (state == i2c_pkg::ST_IDLE) begin
                addr_r   <= i2c_addr;
                data_w_r <= i2c_data_w;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/i2c_master.sv
// I2C EEPROM master
`timescale 1ns/1ns
`include "i2c_cfg.svh"
`default_nettype none

module i2c_master (
    input  logic                    dri_clk,       // four times the scl rate
    input  logic                    rst_n,
    input  logic                    i2c_exec,
    input  logic                    bit_ctrl,      // 1: 16-bit word address
    input  logic                    i2c_rh_wl,     // 1: read
    input  logic [`I2C_WADDR_W-1:0] i2c_addr,
    input  logic [`I2C_BYTE_W-1:0]  i2c_data_w,
    output logic [`I2C_BYTE_W-1:0]  i2c_data_r,
    output logic                    i2c_done,
    output logic                    i2c_ack,       // 1: some ack slot missed
    output logic                    scl,
    inout  wire                     sda
);

    logic                   op_go;
    logic                   op_done;
    logic                   ack_n;
    logic                   sda_drive_low;
    logic                   sda_in;
    i2c_pkg::i2c_op_e       op;
    logic [`I2C_BYTE_W-1:0] tx_byte;
    logic [`I2C_BYTE_W-1:0] rx_byte;

    // open drain, pull-up sits outside
    assign sda    = sda_drive_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

    i2c_seq u_seq (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .op_done    (op_done),
        .ack_n      (ack_n),
        .rx_byte    (rx_byte),
        .op_go      (op_go),
        .op         (op),
        .tx_byte    (tx_byte),
        .i2c_data_r (i2c_data_r),
        .i2c_done   (i2c_done),
        .i2c_ack    (i2c_ack)
    );

    i2c_byte_engine u_engine (
        .dri_clk       (dri_clk),
        .rst_n         (rst_n),
        .op_go         (op_go),
        .op            (op),
        .tx_byte       (tx_byte),
        .sda_in        (sda_in),
        .op_done       (op_done),
        .ack_n         (ack_n),
        .rx_byte       (rx_byte),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

endmodule

`default_nettype wire

//--- verification/i2c_eeprom_model.sv
// Behavioral I2C EEPROM slave
`timescale 1ns/1ns
`include "i2c_cfg.svh"
`default_nettype none

module i2c_eeprom_model (
    input  logic scl,
    inout  wire  sda,
    input  logic present            // 0: never acks, bus untouched
);

    localparam int PH_IDLE = 0;     // waiting for a start
    localparam int PH_DEV  = 1;     // device address byte
    localparam int PH_WR   = 2;     // word address and data bytes
    localparam int PH_RD   = 3;     // sending one byte

    logic [7:0]  mem [0:65535];
    logic [7:0]  wbuf [0:2];        // bytes written after the device address
    logic [7:0]  sh;
    logic [7:0]  tx;
    logic [15:0] ptr;
    logic        drive_low;
    logic        rd_mode;
    logic        scl_q;
    logic        sda_q;
    int          phase;
    int          cnt;               // scl rises within the current byte
    int          nbytes;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        for (int a = 0; a < 65536; a++) begin
            mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'hA5;
        end
        drive_low = 1'b0;
        rd_mode   = 1'b0;
        scl_q     = 1'b1;
        sda_q     = 1'b1;
        phase     = PH_IDLE;
        cnt       = 0;
        nbytes    = 0;
    end

    // end of a byte, ack slot included
    task byte_done;
        case (phase)
            PH_DEV: begin
                if (sh[0]) begin
                    // one address byte means 8-bit mode, upper byte zero
                    ptr       = (nbytes >= 2) ? {wbuf[0], wbuf[1]} : {8'h00, wbuf[0]};
                    tx        = mem[ptr];
                    rd_mode   = 1'b1;
                    phase     = PH_RD;
                    drive_low = !tx[7];           // first data bit
                end
                else begin
                    nbytes  = 0;
                    rd_mode = 1'b0;
                    phase   = PH_WR;
                end
            end
            PH_WR: begin
                if (nbytes < 3) begin
                    wbuf[nbytes] = sh;
                end
                nbytes = nbytes + 1;
            end
            default: phase = PH_IDLE;             // master nack ends the read
        endcase
    endtask

    task scl_fall;
        case (cnt)
            8: begin
                if (phase == PH_RD) begin
                    drive_low = 1'b0;             // master answers
                end
                else if (present && (phase == PH_WR || sh[7:1] == `I2C_SLAVE_ADDR)) begin
                    drive_low = 1'b1;             // ack
                end
                else begin
                    drive_low = 1'b0;
                    phase     = PH_IDLE;
                end
            end
            9: begin
                drive_low = 1'b0;
                cnt       = 0;
                byte_done();
            end
            default: begin
                if (phase == PH_RD && cnt > 0) begin
                    drive_low = !tx[7-cnt];
                end
            end
        endcase
    endtask

    task stop_seen;
        if (!rd_mode && nbytes == 3) begin
            mem[{wbuf[0], wbuf[1]}] = wbuf[2];
        end
        else if (!rd_mode && nbytes == 2) begin
            mem[{8'h00, wbuf[0]}] = wbuf[1];
        end
        phase     = PH_IDLE;
        drive_low = 1'b0;
        nbytes    = 0;
        rd_mode   = 1'b0;
    endtask

    // ----------------------------------------
    // bus watcher
    // ----------------------------------------
    always @(scl or sda) begin
        if (scl !== scl_q) begin
            if (scl === 1'b1 && phase != PH_IDLE) begin
                if (cnt < 8) begin
                    sh = {sh[6:0], sda === 1'b1};
                end
                cnt = cnt + 1;
            end
            else if (scl === 1'b0 && phase != PH_IDLE) begin
                scl_fall();
            end
        end
        else if (scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
            phase     = PH_DEV;                   // start or repeated start
            cnt       = 0;
            drive_low = 1'b0;
        end
        else if (scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
            stop_seen();
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire

//--- verification/i2c_master_assertions.sv
// I2C master bound checks
`timescale 1ns/1ns
`default_nettype none

module i2c_master_assertions (
    input logic                dri_clk,
    input logic                rst_n,
    input i2c_pkg::i2c_state_e state,
    input logic                op_go,
    input logic                cmd_active,
    input logic                i2c_done,
    input logic                scl
);

    int unsigned fail_count = 0;

    done_pulse: assert property (@(posedge dri_clk) disable iff (!rst_n)
        i2c_done |=> !i2c_done)
        else begin
            fail_count++;
            $error("i2c_done high for two cycles");
        end

    // bus idles with scl high
    idle_scl: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (state == i2c_pkg::ST_IDLE) |-> scl)
        else begin
            fail_count++;
            $error("scl low while the sequencer is idle");
        end

    one_cmd: assert property (@(posedge dri_clk) disable iff (!rst_n)
        op_go |-> !cmd_active)
        else begin
            fail_count++;
            $error("op_go while an engine command is active");
        end

endmodule

bind i2c_master i2c_master_assertions u_assertions (
    .dri_clk    (dri_clk),
    .rst_n      (rst_n),
    .state      (u_seq.state),
    .op_go      (op_go),
    .cmd_active (u_seq.cmd_active),
    .i2c_done   (i2c_done),
    .scl        (scl)
);

`default_nettype wire

//--- verification/tb_i2c_master.sv
// I2C master testbench
`timescale 1ns/1ns
`include "i2c_cfg.svh"
`default_nettype none

module tb_i2c_master;

    localparam int N_TRANS    = 48;
    localparam int MAX_CYCLES = N_TRANS * 260 + 100;

    logic                    dri_clk;
    logic                    rst_n;
    logic                    i2c_exec;
    logic                    bit_ctrl;
    logic                    i2c_rh_wl;
    logic [`I2C_WADDR_W-1:0] i2c_addr;
    logic [`I2C_BYTE_W-1:0]  i2c_data_w;
    logic [`I2C_BYTE_W-1:0]  i2c_data_r;
    logic                    i2c_done;
    logic                    i2c_ack;
    logic                    scl;
    wire                     sda;
    logic                    present;

    logic [`I2C_BYTE_W-1:0]  shadow [0:65535];
    logic [15:0]             lfsr;
    logic [15:0]             rnd;
    logic                    r_mode;
    logic                    r_rd;
    logic [15:0]             r_addr;
    logic [`I2C_BYTE_W-1:0]  cur_data;
    logic                    cur_cmp;
    logic                    cur_ack;
    int                      cycles = 0;
    int                      data_errs;
    int                      flag_errs;
    int                      other_errs;
    int                      assert_errs;
    logic                    cmp_q [$];           // data compared on this done
    logic [`I2C_BYTE_W-1:0]  data_q [$];
    logic                    ack_q [$];

    pullup (sda);

    i2c_master DUT (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .i2c_data_r (i2c_data_r),
        .i2c_done   (i2c_done),
        .i2c_ack    (i2c_ack),
        .scl        (scl),
        .sda        (sda)
    );

    i2c_eeprom_model u_eeprom (
        .scl     (scl),
        .sda     (sda),
        .present (present)
    );

    initial begin
        dri_clk = 1'b0;
        forever #20 dri_clk = ~dri_clk;
    end

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    // shadow memory where 8-bit mode sees the upper address byte as zero
    function automatic void ref_transfer(input logic mode16, input logic rd,
        input logic [15:0] addr, input logic [7:0] wdata, input logic here,
        output logic [7:0] exp_data, output logic exp_ack);
        logic [15:0] eff;
        eff      = mode16 ? addr : {8'h00, addr[7:0]};
        exp_ack  = !here;                         // absent slave nacks every slot
        exp_data = shadow[eff];
        if (here && !rd) begin
            shadow[eff] = wdata;
        end
    endfunction

    task automatic check_data(input string name, input logic [`I2C_BYTE_W-1:0] exp,
        input logic [`I2C_BYTE_W-1:0] act);
        if (act !== exp) begin
            data_errs++;
            $display("[FAIL] %0t ns %s expected %02h got %02h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errs++;
            $display("[FAIL] %0t ns %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic run_transfer(input logic mode16, input logic rd,
        input logic [15:0] addr, input logic [7:0] wdata);
        logic [7:0] exp_data;
        logic       exp_ack;
        ref_transfer(mode16, rd, addr, wdata, present, exp_data, exp_ack);
        cmp_q.push_back(rd && present);
        data_q.push_back(exp_data);
        ack_q.push_back(exp_ack);
        @(posedge dri_clk);
        #5;
        bit_ctrl   = mode16;
        i2c_rh_wl  = rd;
        i2c_addr   = addr;
        i2c_data_w = wdata;
        i2c_exec   = 1'b1;
        @(posedge dri_clk);
        #5;
        i2c_exec = 1'b0;
        @(negedge dri_clk);
        while (i2c_done !== 1'b1) begin
            @(negedge dri_clk);
        end
    endtask

    // ----------------------------------------
    // result checking
    // ----------------------------------------
    always @(negedge dri_clk) begin
        if (i2c_done === 1'b1) begin
            if (ack_q.size() == 0) begin
                other_errs++;
                $display("i2c_done pulsed at %0t ns with no request outstanding", $time);
            end
            else begin
                cur_cmp  = cmp_q.pop_front();
                cur_data = data_q.pop_front();
                cur_ack  = ack_q.pop_front();
                check_flag("i2c_ack", cur_ack, i2c_ack);
                if (cur_cmp) begin
                    check_data("i2c_data_r", cur_data, i2c_data_r);
                end
            end
        end
    end

    always @(posedge dri_clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        rst_n      = 1'b0;
        i2c_exec   = 1'b0;
        bit_ctrl   = 1'b0;
        i2c_rh_wl  = 1'b0;
        i2c_addr   = '0;
        i2c_data_w = '0;
        present    = 1'b1;
        lfsr       = 16'd90;
        data_errs  = 0;
        flag_errs  = 0;
        other_errs = 0;
        for (int a = 0; a < 65536; a++) begin
            shadow[a] = 8'(a) ^ 8'(a >> 8) ^ 8'hA5;   // same fill as the slave
        end
        repeat (4) @(posedge dri_clk);
        #5;
        rst_n = 1'b1;
        repeat (2) @(negedge dri_clk);

        // idle bus after reset
        check_flag("scl", 1'b1, scl);
        check_flag("sda", 1'b1, sda);
        check_flag("i2c_done", 1'b0, i2c_done);
        check_flag("i2c_ack", 1'b0, i2c_ack);
        check_data("i2c_data_r", 8'h00, i2c_data_r);

        run_transfer(1'b1, 1'b0, 16'h1234, 8'hC3);
        run_transfer(1'b1, 1'b1, 16'h1234, 8'h00);

        // upper address byte dropped in 8-bit mode
        run_transfer(1'b0, 1'b0, 16'h3C47, 8'h5E);
        run_transfer(1'b0, 1'b1, 16'h9947, 8'h00);
        run_transfer(1'b1, 1'b1, 16'h0047, 8'h00);

        @(posedge dri_clk);
        #5;
        present = 1'b0;                           // no slave on the bus
        run_transfer(1'b1, 1'b0, 16'h0200, 8'h77);
        run_transfer(1'b1, 1'b1, 16'h0200, 8'h00);
        @(posedge dri_clk);
        #5;
        present = 1'b1;
        run_transfer(1'b1, 1'b1, 16'h0200, 8'h00);

        // random mix in a small window
        repeat (40) begin
            take_bits(1, rnd);
            r_mode = rnd[0];
            take_bits(1, rnd);
            r_rd = rnd[0];
            take_bits(5, rnd);
            r_addr = {7'b0, rnd[4], 4'h3, rnd[3:0]};
            take_bits(8, rnd);
            run_transfer(r_mode, r_rd, r_addr, rnd[7:0]);
        end

        repeat (4) @(posedge dri_clk);
        if (ack_q.size() != 0) begin
            other_errs++;
            $display("%0d transactions never reported i2c_done", ack_q.size());
        end
        assert_errs = DUT.u_assertions.fail_count;
        $display("errors: data %0d, flag %0d, assertion %0d, other %0d",
                 data_errs, flag_errs, assert_errs, other_errs);
        if (data_errs + flag_errs + assert_errs + other_errs == 0) begin
            $display("PASS: all tests");
        end
        else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
rtl/i2c_pkg.sv
rtl/i2c_byte_engine.sv
rtl/i2c_seq.sv
rtl/i2c_master.sv
verification/i2c_eeprom_model.sv
verification/i2c_master_assertions.sv
verification/tb_i2c_master.sv

//--- Bender.yml
package:
  name: i2c_master

export_include_dirs:
  - include

sources:
  - files:
      - rtl/i2c_pkg.sv
      - rtl/i2c_byte_engine.sv
      - rtl/i2c_seq.sv
      - rtl/i2c_master.sv
  - target: simulation
    files:
      - verification/i2c_eeprom_model.sv
      - verification/i2c_master_assertions.sv
      - verification/tb_i2c_master.sv
